// File: common/audioPkg.sv
package audioPkg;

	////////////////////////////////////////////////////////////
	// sample format
	////////////////////////////////////////////////////////////

	// bits per channel, PCM1808 delivers 24
	localparam int SampleWidth = 24;

	// stereo ADC
	localparam int NumChannels = 2;

	// channel index, 0 while lrck is low
	localparam int LeftChannel = 0;
	localparam int RightChannel = 1;

	////////////////////////////////////////////////////////////
	// frame timing
	////////////////////////////////////////////////////////////

	// frame counter, 256 clk per lrck period plus one spare bit
	localparam int PrescalerWidth = 9;

	// data slots inside each lrck half, slot 0 is the lrck edge
	localparam int FirstSlot = 1;
	localparam int LastSlot = 24;

	// slot where both channels are complete and get latched
	localparam int StrobeSlot = 25;

	// one channel sample
	typedef logic [SampleWidth-1:0] sampleT;

endpackage

// File: common/spiPkg.sv
package spiPkg;

	////////////////////////////////////////////////////////////
	// MCU readout port
	////////////////////////////////////////////////////////////

	// equalizer coefficient word shifted in on sdi
	localparam int CoeffWidth = 32;

	// sample byte shifted out on sdo
	localparam int ByteWidth = 8;

	// flops in front of sck, sdi and load
	localparam int SyncStages = 2;

	// coefficient word, MSB arrives first
	typedef logic [CoeffWidth-1:0] coeffT;

	// readout byte, MSB leaves first
	typedef logic [ByteWidth-1:0] byteT;

endpackage

// File: hdl/i2sClockGen.sv
`timescale 1ns/1ps

module i2sClockGen
(
	input logic clk,
	input logic reset,
	output logic scki,
	output logic bck,
	output logic lrck,
	output logic shiftEnable,
	output logic sampleStrobe
);
	import audioPkg::*;

	// slot number is prescaler bits 6 to 2 with 32 slots per lrck half
	localparam int SlotWidth = 5;
	localparam logic [SlotWidth-1:0] FirstSlotCode = SlotWidth'(FirstSlot);
	localparam logic [SlotWidth-1:0] LastSlotCode = SlotWidth'(LastSlot);
	localparam logic [SlotWidth-1:0] StrobeSlotCode = SlotWidth'(StrobeSlot);

	logic [PrescalerWidth-1:0] prescaler;
	logic [1:0] phase;
	logic [SlotWidth-1:0] slot;
	logic dataSlot;

	// free running frame counter
	always_ff @(posedge clk)
	begin
		if (reset)
			prescaler <= '0;
		else
			prescaler <= prescaler + PrescalerWidth'(1);
	end

	// ADC system clock is clk itself at 256 fs
	assign scki = clk;
	// 64 fs bit clock and fs word clock
	assign bck = prescaler[1];
	assign lrck = prescaler[7];

	// position inside one bck period and inside one lrck half
	assign phase = prescaler[1:0];
	assign slot = prescaler[6:2];
	assign dataSlot = (slot >= FirstSlotCode) && (slot <= LastSlotCode);

	// phase 1 is the last clk before bck rises
	assign shiftEnable = dataSlot && (phase == 2'd1);

	// prescaler 228 is slot 25 of the right half at phase 0
	assign sampleStrobe = lrck && (slot == StrobeSlotCode) && (phase == 2'd0);

	// latch point lies outside every data slot
	strobeNotShift: assert property (@(posedge clk) disable iff (reset)
		!(sampleStrobe && shiftEnable))
		else $error("sampleStrobe overlaps shiftEnable");

endmodule

// File: i2s/i2sChannelShifter.sv
`timescale 1ns/1ps

module i2sChannelShifter
#(
	parameter int ChannelSel = audioPkg::LeftChannel,
	parameter int SampleWidth = audioPkg::SampleWidth
)
(
	input logic clk,
	input logic reset,
	input logic din,
	input logic lrck,
	input logic shiftEnable,
	output audioPkg::sampleT shiftWord
);
	import audioPkg::*;

	// lrck level that selects this channel
	localparam logic SelLevel = (ChannelSel == RightChannel);
	// data bits in one lrck half
	localparam int SlotsPerHalf = LastSlot - FirstSlot + 1;
	localparam int CountWidth = $clog2(SlotsPerHalf + 1);

	logic selected;
	logic [CountWidth-1:0] bitCount;

	assign selected = (lrck == SelLevel);

	// MSB first, so each new bit enters at the bottom
	always_ff @(posedge clk)
	begin
		if (selected && shiftEnable)
			shiftWord <= {shiftWord[SampleWidth-2:0], din};
	end

	// bits taken in the current half, cleared in the other channel's half
	always_ff @(posedge clk)
	begin
		if (reset || !selected)
			bitCount <= '0;
		else if (shiftEnable)
			bitCount <= bitCount + CountWidth'(1);
	end

	// never more than one sample's worth of bits per lrck half
	shiftLimit: assert property (@(posedge clk) disable iff (reset)
		(selected && shiftEnable) |-> (bitCount < CountWidth'(SlotsPerHalf)))
		else $error("channel %0d shifted past %0d bits", ChannelSel, SlotsPerHalf);

endmodule

// File: i2s/i2sSampleRegister.sv
`timescale 1ns/1ps

module i2sSampleRegister
#(
	parameter int SampleWidth = audioPkg::SampleWidth
)
(
	input logic clk,
	input logic reset,
	input logic sampleStrobe,
	input audioPkg::sampleT leftShift,
	input audioPkg::sampleT rightShift,
	output audioPkg::sampleT left,
	output audioPkg::sampleT right
);

	////////////////////////////////////////////////////////////
	// frame latch
	////////////////////////////////////////////////////////////

	// both words move together on the one strobe per frame
	// so left and right always come from the same lrck period
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			left <= SampleWidth'(0);
			right <= SampleWidth'(0);
		end
		else if (sampleStrobe)
		begin
			left <= leftShift;
			right <= rightShift;
		end
	end

endmodule

// File: hdl/sampleCapture.sv
`timescale 1ns/1ps

module sampleCapture
#(
	parameter int SampleWidth = audioPkg::SampleWidth
)
(
	input logic clk,
	input logic reset,
	input audioPkg::sampleT left,
	input logic loadSync,
	output logic done,
	output spiPkg::byteT sampleByte
);
	import spiPkg::*;

	// top byte of the left word, follows it while load is high
	byteT trackByte;

	// load high tracks, load low freezes and flags done
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			trackByte <= '0;
			done <= 1'b0;
		end
		else if (loadSync)
		begin
			trackByte <= left[SampleWidth-1 -: ByteWidth];
			done <= 1'b0;
		end
		else
			done <= 1'b1;
	end

	// trackByte stops moving once load is low, so this holds the frozen byte
	always_ff @(posedge clk)
	begin
		if (!loadSync)
			sampleByte <= trackByte;
	end

	// done drops the cycle after load comes back
	doneClearsOnLoad: assert property (@(posedge clk) disable iff (reset)
		loadSync |=> !done)
		else $error("done high after loadSync");

endmodule

// File: spi/spiSlave.sv
`timescale 1ns/1ps

module spiSlave
#(
	parameter int CoeffWidth = spiPkg::CoeffWidth
)
(
	input logic clk,
	input logic reset,
	input logic sck,
	input logic sdi,
	input logic load,
	input logic done,
	input spiPkg::byteT sampleByte,
	output logic loadSync,
	output logic sdo,
	output spiPkg::coeffT coeffs
);
	import spiPkg::*;

	// bit positions of the three pins inside one synchronizer stage
	localparam int SckBit = 2;
	localparam int SdiBit = 1;
	localparam int LoadBit = 0;

	logic [SyncStages-1:0][2:0] syncPipe;
	logic sckSync;
	logic sdiSync;
	logic sckPrev;
	logic sckRise;
	logic sckFall;
	logic donePrev;
	logic doneRise;
	byteT shiftOut;

	////////////////////////////////////////////////////////////
	// pin synchronizers and edge detect
	////////////////////////////////////////////////////////////

	// one chain for sck, sdi and load keeps sdi aligned with sck
	always_ff @(posedge clk)
	begin
		syncPipe[0] <= {sck, sdi, load};
		for (int i = 1; i < SyncStages; i++)
			syncPipe[i] <= syncPipe[i-1];
		sckPrev <= sckSync;
	end

	assign sckSync = syncPipe[SyncStages-1][SckBit];
	assign sdiSync = syncPipe[SyncStages-1][SdiBit];
	assign loadSync = syncPipe[SyncStages-1][LoadBit];

	// pin edge acts on the 3rd clk after two sync flops and the action register
	assign sckRise = sckSync && !sckPrev;
	assign sckFall = !sckSync && sckPrev;

	// done comes from sampleCapture in this clock domain
	always_ff @(posedge clk)
	begin
		if (reset)
			donePrev <= 1'b0;
		else
			donePrev <= done;
	end

	assign doneRise = done && !donePrev;

	////////////////////////////////////////////////////////////
	// coefficient shift-in
	////////////////////////////////////////////////////////////

	// MCU sets sdi before the sck rise with the MSB first
	always_ff @(posedge clk)
	begin
		if (reset)
			coeffs <= '0;
		else if (sckRise)
			coeffs <= {coeffs[CoeffWidth-2:0], sdiSync};
	end

	////////////////////////////////////////////////////////////
	// sample byte shift-out
	////////////////////////////////////////////////////////////

	// new capture puts the MSB on sdo before the first sck rise
	// each sck fall then moves the next bit up
	always_ff @(posedge clk)
	begin
		if (reset)
			shiftOut <= '0;
		else if (doneRise)
			shiftOut <= sampleByte;
		else if (sckFall)
			shiftOut <= {shiftOut[ByteWidth-2:0], 1'b0};
	end

	assign sdo = shiftOut[ByteWidth-1];

endmodule

// File: hdl/eqSampleTop.sv
`timescale 1ns/1ps

module eqSampleTop
#(
	parameter int SampleWidth = audioPkg::SampleWidth,
	parameter int CoeffWidth = spiPkg::CoeffWidth
)
(
	input logic clk,
	input logic reset,
	input logic din,
	input logic sck,
	input logic sdi,
	input logic load,
	output logic bck,
	output logic lrck,
	output logic scki,
	output logic sdo,
	output logic done,
	output audioPkg::sampleT left,
	output audioPkg::sampleT right,
	output spiPkg::coeffT coeffs
);
	import audioPkg::*;
	import spiPkg::*;

	logic shiftEnable;
	logic sampleStrobe;
	logic loadSync;
	sampleT shiftWords [NumChannels];
	byteT sampleByte;

	////////////////////////////////////////////////////////////
	// I2S capture
	////////////////////////////////////////////////////////////

	// ADC clocks and the shift/latch strobes
	i2sClockGen i2sClockGen_inst (
		.clk(clk),
		.reset(reset),
		.scki(scki),
		.bck(bck),
		.lrck(lrck),
		.shiftEnable(shiftEnable),
		.sampleStrobe(sampleStrobe)
	);

	// one shifter per lrck half, index picks the lrck level
	for (genvar ch = 0; ch < NumChannels; ch++)
	begin : genShifter
		i2sChannelShifter #(
			.ChannelSel(ch),
			.SampleWidth(SampleWidth)
		) i2sChannelShifter_inst (
			.clk(clk),
			.reset(reset),
			.din(din),
			.lrck(lrck),
			.shiftEnable(shiftEnable),
			.shiftWord(shiftWords[ch])
		);
	end

	// paired left/right words, once per frame
	i2sSampleRegister #(
		.SampleWidth(SampleWidth)
	) i2sSampleRegister_inst (
		.clk(clk),
		.reset(reset),
		.sampleStrobe(sampleStrobe),
		.leftShift(shiftWords[LeftChannel]),
		.rightShift(shiftWords[RightChannel]),
		.left(left),
		.right(right)
	);

	////////////////////////////////////////////////////////////
	// MCU readout
	////////////////////////////////////////////////////////////

	// load/done handshake on the left word
	sampleCapture #(
		.SampleWidth(SampleWidth)
	) sampleCapture_inst (
		.clk(clk),
		.reset(reset),
		.left(left),
		.loadSync(loadSync),
		.done(done),
		.sampleByte(sampleByte)
	);

	// sck/sdi/load come in here, load goes back out synchronized
	spiSlave #(
		.CoeffWidth(CoeffWidth)
	) spiSlave_inst (
		.clk(clk),
		.reset(reset),
		.sck(sck),
		.sdi(sdi),
		.load(load),
		.done(done),
		.sampleByte(sampleByte),
		.loadSync(loadSync),
		.sdo(sdo),
		.coeffs(coeffs)
	);

endmodule

// File: dv/eqSampleTbTasks.svh
`ifndef EQ_SAMPLE_TB_TASKS_SVH
`define EQ_SAMPLE_TB_TASKS_SVH

// report one error and stop the run
task automatic failNow(input string msg);
	$display("%s", msg);
	$display("TB FAILED");
	$fatal(1);
endtask

// idle the MCU for n clk
task automatic holdCycles(input int n);
	repeat (n) @(negedge clk);
endtask

// wait for a given position in the lrck frame
task automatic waitFramePos(input logic [7:0] pos, input int maxCycles);
	int count;
	count = 0;
	while (tbCount[7:0] != pos)
	begin
		@(negedge clk);
		count++;
		if (count > maxCycles)
			failNow("timeout waiting for frame position");
	end
endtask

// wait for the capture handshake
task automatic waitDone(input int maxCycles);
	int count;
	count = 0;
	while (!done)
	begin
		@(negedge clk);
		count++;
		if (count > maxCycles)
			failNow("timeout waiting for done");
	end
endtask

// SPI read with the MSB first and sdo checked before each sck rise
task automatic readByte();
	for (int i = 7; i >= 0; i--)
	begin
		@(negedge clk);
		readIdx = 3'(i);
		readCheck = 1'b1;
		@(negedge clk);
		readCheck = 1'b0;
		sck = 1'b1;
		holdCycles(4);
		sck = 1'b0;
		// sck fall reaches sdo 3 clk later
		holdCycles(5);
	end
endtask

// SPI write of one coefficient word with the MSB first
task automatic writeCoeff(input coeffT word);
	expCoeff = word;
	for (int i = 31; i >= 0; i--)
	begin
		sdi = word[i];
		holdCycles(2);
		sck = 1'b1;
		holdCycles(4);
		sck = 1'b0;
		holdCycles(2);
	end
	holdCycles(4);
	coeffCheck = 1'b1;
	@(negedge clk);
	coeffCheck = 1'b0;
	sdi = 1'b0;
endtask

`endif

// File: dv/eqSampleTb.sv
`timescale 1ns/1ps

module eqSampleTb;
	import audioPkg::*;
	import spiPkg::*;

	logic clk = 1'b0;
	logic reset;
	logic din = 1'b0;
	logic sck;
	logic sdi;
	logic load;
	logic bck;
	logic lrck;
	logic scki;
	logic sdo;
	logic done;
	sampleT left;
	sampleT right;
	coeffT coeffs;

	// frame position counted from reset
	logic [8:0] tbCount;
	// frame the ADC model is sending and the left word latched at the last strobe
	sampleT curLeft = '0;
	sampleT curRight = '0;
	sampleT latchedLeft = '0;
	// readout and coefficient references
	byteT expByte;
	coeffT expCoeff;
	logic readCheck;
	logic [2:0] readIdx;
	logic coeffCheck;
	// cycles since load last changed level
	int loadHighCount = 0;
	int loadLowCount = 0;

	`include "eqSampleTbTasks.svh"

	eqSampleTop eqSampleTop_inst (
		.clk(clk),
		.reset(reset),
		.din(din),
		.sck(sck),
		.sdi(sdi),
		.load(load),
		.bck(bck),
		.lrck(lrck),
		.scki(scki),
		.sdo(sdo),
		.done(done),
		.left(left),
		.right(right),
		.coeffs(coeffs)
	);

	// 20 ns clock
	always #10 clk = ~clk;

	////////////////////////////////////////////////////////////
	// reference counters
	////////////////////////////////////////////////////////////

	always @(posedge clk)
	begin
		if (reset)
			tbCount <= 9'd0;
		else
			tbCount <= tbCount + 9'd1;
	end

	// frame latch point is prescaler 228
	always @(posedge clk)
	begin
		if (!reset && tbCount[7:0] == 8'd228)
			latchedLeft <= curLeft;
	end

	always @(posedge clk)
	begin
		if (!load)
			loadHighCount <= 0;
		else if (loadHighCount < 1000)
			loadHighCount <= loadHighCount + 1;
		if (load)
			loadLowCount <= 0;
		else if (loadLowCount < 1000)
			loadLowCount <= loadLowCount + 1;
	end

	////////////////////////////////////////////////////////////
	// ADC model
	////////////////////////////////////////////////////////////

	// new pair at frame start with the MSB in slot 1 of each lrck half
	always @(negedge clk)
	begin : adcModel
		logic [4:0] slot;
		int bitPos;
		slot = tbCount[6:2];
		if (tbCount[7:0] == 8'd0)
		begin
			curLeft = sampleT'($urandom);
			curRight = sampleT'($urandom);
		end
		if (slot >= 5'd1 && slot <= 5'd24)
		begin
			bitPos = 24 - int'(slot);
			din = tbCount[7] ? curRight[bitPos] : curLeft[bitPos];
		end
		else
			din = 1'b0;
	end

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////

	resetFlags: assert property (@(posedge clk) $fell(reset) |->
		(!bck && !lrck && !done && !sdo))
		else failNow($sformatf("FAILED at %0t: bck/lrck/done/sdo expected 0000 got %b%b%b%b",
			$time, bck, lrck, done, sdo));

	resetWords: assert property (@(posedge clk) $fell(reset) |->
		(left == '0 && right == '0 && coeffs == '0))
		else failNow($sformatf("FAILED at %0t: left/right/coeffs expected 0 got %h/%h/%h",
			$time, left, right, coeffs));

	// scki follows clk on both edges
	sckiAtRise: assert property (@(posedge clk) scki == clk)
		else failNow($sformatf("FAILED at %0t: scki expected %b got %b",
			$time, $sampled(clk), $sampled(scki)));

	sckiAtFall: assert property (@(negedge clk) scki == clk)
		else failNow($sformatf("FAILED at %0t: scki expected %b got %b",
			$time, $sampled(clk), $sampled(scki)));

	// bck toggles every 2 clk
	bckPhase: assert property (@(posedge clk) disable iff (reset) bck == tbCount[1])
		else failNow($sformatf("FAILED at %0t: bck expected %b got %b", $time, tbCount[1], bck));

	// lrck toggles every 128 clk
	lrckPhase: assert property (@(posedge clk) disable iff (reset) lrck == tbCount[7])
		else failNow($sformatf("FAILED at %0t: lrck expected %b got %b", $time, tbCount[7], lrck));

	frameLeft: assert property (@(posedge clk) disable iff (reset)
		(tbCount[7:0] == 8'd229) |-> (left == curLeft))
		else failNow($sformatf("FAILED at %0t: left expected %h got %h", $time, curLeft, left));

	frameRight: assert property (@(posedge clk) disable iff (reset)
		(tbCount[7:0] == 8'd229) |-> (right == curRight))
		else failNow($sformatf("FAILED at %0t: right expected %h got %h", $time, curRight, right));

	// load held high keeps done low
	doneHeldLow: assert property (@(posedge clk) disable iff (reset)
		((loadHighCount >= 4) || (loadLowCount >= 1 && loadLowCount <= 2)) |-> !done)
		else failNow($sformatf("FAILED at %0t: done expected 0 got %b", $time, done));

	// 3 clk from load pin fall to done
	doneRises: assert property (@(posedge clk) disable iff (reset)
		(loadLowCount >= 3) |-> done)
		else failNow($sformatf("FAILED at %0t: done expected 1 got %b", $time, done));

	sdoBit: assert property (@(posedge clk) disable iff (reset)
		readCheck |-> (sdo == expByte[readIdx]))
		else failNow($sformatf("FAILED at %0t: sdo bit %0d expected %b got %b",
			$time, readIdx, expByte[readIdx], sdo));

	coeffValue: assert property (@(posedge clk) disable iff (reset)
		coeffCheck |-> (coeffs == expCoeff))
		else failNow($sformatf("FAILED at %0t: coeffs expected %h got %h",
			$time, expCoeff, coeffs));

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////

	initial
	begin
		void'($urandom(32'hb1b7));
		reset = 1'b1;
		sck = 1'b0;
		sdi = 1'b0;
		load = 1'b1;
		readCheck = 1'b0;
		readIdx = 3'd0;
		coeffCheck = 1'b0;
		expByte = '0;
		expCoeff = '0;
		holdCycles(2);
		reset = 1'b0;

		for (int round = 0; round < 3; round++)
		begin
			// let at least one full frame land in left/right
			holdCycles(260);
			waitFramePos(8'd50, 600);
			load = 1'b0;
			expByte = latchedLeft[SampleWidth-1 -: ByteWidth];
			waitDone(20);
			holdCycles(3);
			readByte();
			writeCoeff(coeffT'($urandom));
			load = 1'b1;
			holdCycles(8);
		end

		$display("TB PASSED");
		$finish;
	end

	// overall limit on run time
	initial
	begin
		#500000;
		failNow("simulation ran past its time limit");
	end

endmodule

// File: list.f
+incdir+dv
common/audioPkg.sv
common/spiPkg.sv
hdl/i2sClockGen.sv
i2s/i2sChannelShifter.sv
i2s/i2sSampleRegister.sv
hdl/sampleCapture.sv
spi/spiSlave.sv
hdl/eqSampleTop.sv
dv/eqSampleTb.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator, verdict from the log
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module eqSampleTb -f list.f -o eqSampleSim \
	&& ./obj_dir/eqSampleSim | tee sim.log \
	|| { echo "build or simulation did not complete"; exit 1; }

grep -q "TB FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "TB PASSED" sim.log || { echo "no pass line in sim.log"; exit 1; }
exit 0
